// File: hw/sha_sched_pkg.sv
// shared widths, types and sigma functions for the sha-256 message schedule
`default_nettype none

package sha_sched_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int BLOCK_WORDS  = 16;
    localparam int BLOCK_BYTES  = 64;
    localparam int SCHED_ROUNDS = 64;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0]  word_index_t;

    // word 0 sits in the top 32 bits
    typedef word_t [0:BLOCK_WORDS-1] block_t;

    typedef struct packed {
        word_t       data;
        word_index_t index;
        logic        last;
    } sched_word_s;

    ////////////////////////////////////////////////////////////
    // sigma functions
    ////////////////////////////////////////////////////////////

    function automatic word_t rotr(word_t x, int unsigned n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic word_t small_sigma0(word_t x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic word_t small_sigma1(word_t x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

endpackage

`default_nettype wire

// File: hw/msg_block_loader.sv
// byte stream to 512-bit block packer for the sha-256 message schedule
`timescale 1ns/1ps
`default_nettype none

module msg_block_loader (
    input  wire                  clk,
    input  wire                  reset,

    // byte stream in
    input  wire                  byte_valid,
    input  sha_sched_pkg::byte_t byte_data,
    output logic                 byte_ready,

    // block out to the expander
    output logic                 block_valid,
    output sha_sched_pkg::block_t block_data,
    input  wire                  block_ready
);

    import sha_sched_pkg::*;

    localparam int CNT_W = $clog2(BLOCK_BYTES);

    logic [CNT_W-1:0]             byte_cnt_q;
    logic [$clog2(BLOCK_WORDS)-1:0] word_sel;
    logic                         full_q;
    logic                         last_byte;
    logic                         byte_take;
    logic                         block_take;
    block_t                       block_q;

    ////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////

    assign byte_ready  = !full_q;
    assign block_valid = full_q;
    assign block_data  = block_q;

    assign byte_take  = byte_valid && byte_ready;
    assign block_take = block_valid && block_ready;

    // four bytes per word, msb first
    assign word_sel  = byte_cnt_q[CNT_W-1:2];
    assign last_byte = (byte_cnt_q == CNT_W'(BLOCK_BYTES - 1));

    ////////////////////////////////////////////////////////////
    // byte counter and full flag
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            byte_cnt_q <= '0;
            full_q     <= 1'b0;
        end
        else
        begin
            // wraps to zero after the last byte
            if (byte_take)
                byte_cnt_q <= byte_cnt_q + 1'b1;

            if (byte_take && last_byte)
                full_q <= 1'b1;
            else if (block_take)
                full_q <= 1'b0;
        end
    end

    // earlier bytes of the word move up by one byte
    always_ff @(posedge clk)
    begin
        if (byte_take)
            block_q[word_sel] <= {block_q[word_sel][23:0], byte_data};
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // counter sits at zero from the 64th byte until the handover
    a_no_byte_while_full : assert property (
        @(posedge clk) disable iff (reset)
        full_q |-> (byte_cnt_q == '0)
    ) else $error("loader took a byte while holding a full block");

    a_block_stable : assert property (
        @(posedge clk) disable iff (reset)
        (block_valid && !block_ready) |=> (block_valid && $stable(block_data))
    ) else $error("block_data changed while waiting for block_ready");

endmodule

`default_nettype wire

// File: hw/msg_schedule_expander.sv
// sixteen-word window that expands one block into the sha-256 schedule words
`timescale 1ns/1ps
`default_nettype none

module msg_schedule_expander #(
    parameter int ROUNDS = sha_sched_pkg::SCHED_ROUNDS
) (
    input  wire                        clk,
    input  wire                        reset,

    // block in from the loader
    input  wire                        block_valid,
    input  sha_sched_pkg::block_t      block_data,
    output logic                       block_ready,

    // schedule words out
    output logic                       word_valid,
    output sha_sched_pkg::sched_word_s word,
    input  wire                        word_ready
);

    import sha_sched_pkg::*;

    block_t      window_q;
    word_index_t idx_q;
    logic        busy_q;
    logic        last_word;
    logic        block_take;
    logic        word_take;
    word_t       next_word;

    // round count must cover the block and fit the index
    if (ROUNDS < BLOCK_WORDS + 1 || ROUNDS > SCHED_ROUNDS)
    begin : g_bad_rounds
        $error("ROUNDS must be between 17 and 64");
    end

    ////////////////////////////////////////////////////////////
    // handshakes and output word
    ////////////////////////////////////////////////////////////

    assign block_ready = !busy_q;
    assign word_valid  = busy_q;

    assign block_take = block_valid && block_ready;
    assign word_take  = word_valid && word_ready;

    assign last_word = (idx_q == word_index_t'(ROUNDS - 1));

    assign word = '{
        data:  window_q[0],
        index: idx_q,
        last:  last_word
    };

    // window[0] is W(t-16), window[15] is W(t-1)
    assign next_word = small_sigma1(window_q[14]) + window_q[9]
                     + small_sigma0(window_q[1]) + window_q[0];

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end
        else if (block_take)
        begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end
        else if (word_take)
        begin
            idx_q <= idx_q + 1'b1;
            if (last_word)
                busy_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // window
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (block_take)
            window_q <= block_data;
        else if (word_take)
            window_q <= {window_q[1:BLOCK_WORDS-1], next_word};
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_word_stable : assert property (
        @(posedge clk) disable iff (reset)
        (word_valid && !word_ready) |=> (word_valid && $stable(word))
    ) else $error("schedule word changed under back-pressure");

    // the last word hands the expander back to the loader
    a_idle_after_last : assert property (
        @(posedge clk) disable iff (reset)
        (word_take && last_word) |=> block_ready
    ) else $error("expander still busy after the last word");

endmodule

`default_nettype wire

// File: hw/sha_msg_schedule.sv
// sha-256 message schedule generator built from a byte loader and an expander
`timescale 1ns/1ps
`default_nettype none

module sha_msg_schedule #(
    parameter int ROUNDS = sha_sched_pkg::SCHED_ROUNDS
) (
    input  wire                        clk,
    input  wire                        reset,

    // message bytes, msb of each word first
    input  wire                        byte_valid,
    input  sha_sched_pkg::byte_t       byte_data,
    output logic                       byte_ready,

    // schedule words W0 to W(ROUNDS-1)
    output logic                       word_valid,
    output sha_sched_pkg::sched_word_s word,
    input  wire                        word_ready
);

    import sha_sched_pkg::*;

    ////////////////////////////////////////////////////////////
    // loader to expander
    ////////////////////////////////////////////////////////////

    logic   block_valid;
    logic   block_ready;
    block_t block_data;

    // next block fills while the current one expands
    msg_block_loader u_loader (
        .clk         (clk),
        .reset       (reset),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_ready  (byte_ready),
        .block_valid (block_valid),
        .block_data  (block_data),
        .block_ready (block_ready)
    );

    msg_schedule_expander #(
        .ROUNDS (ROUNDS)
    ) u_expander (
        .clk         (clk),
        .reset       (reset),
        .block_valid (block_valid),
        .block_data  (block_data),
        .block_ready (block_ready),
        .word_valid  (word_valid),
        .word        (word),
        .word_ready  (word_ready)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// free-running clock source for the message schedule testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always
    begin
        #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: verif/tb_sha_msg_schedule.sv
// table-driven testbench for the sha-256 message schedule generator
`timescale 1ns/1ps
`default_nettype none

module tb_sha_msg_schedule;

    import sha_sched_pkg::*;

    localparam int NUM_BLOCKS  = 5;
    localparam int CLK_PERIOD  = 8;
    localparam int HOLD_CYCLES = 16;

    typedef struct packed {
        block_t     block;
        logic [7:0] stall_pct;
        logic       known;
        word_t      w16;
        word_t      w63;
    } test_entry_s;

    logic        clk;
    logic        reset;
    logic        byte_valid;
    byte_t       byte_data;
    logic        byte_ready;
    logic        word_valid;
    sched_word_s word;
    logic        word_ready;

    test_entry_s tests [NUM_BLOCKS];
    word_t       expected [SCHED_ROUNDS];
    int          bytes_sent;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk));

    sha_msg_schedule #(.ROUNDS(SCHED_ROUNDS)) UUT (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_ready (byte_ready),
        .word_valid (word_valid),
        .word       (word),
        .word_ready (word_ready)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic word_t rotate_right(word_t x, int n);
        logic [63:0] doubled;
        doubled = {x, x} >> n;
        return doubled[31:0];
    endfunction

    function automatic word_t sched_sigma0(word_t x);
        return rotate_right(x, 7) ^ rotate_right(x, 18) ^ (x >> 3);
    endfunction

    function automatic word_t sched_sigma1(word_t x);
        return rotate_right(x, 17) ^ rotate_right(x, 19) ^ (x >> 10);
    endfunction

    // W0..W15 straight from the block, big-endian
    task automatic build_expected(input block_t blk);
        logic [511:0] flat;
        flat = blk;
        for (int t = 0; t < SCHED_ROUNDS; t++)
        begin
            if (t < BLOCK_WORDS)
                expected[t] = flat[511 - 32*t -: 32];
            else
                expected[t] = sched_sigma1(expected[t-2]) + expected[t-7]
                            + sched_sigma0(expected[t-15]) + expected[t-16];
        end
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] exp,
                               input string what);
        if (actual !== exp)
        begin
            $display("ERROR @ %0t ns: %s: got %h, expected %h", $time, what, actual, exp);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    task automatic fill_table();
        logic [511:0] flat;
        for (int k = 0; k < BLOCK_BYTES; k++)
            flat[511 - 8*k -: 8] = 8'(k);
        tests[0] = '{block: flat, stall_pct: 8'd0, known: 1'b0, w16: '0, w63: '0};
        tests[1] = '{block: '0, stall_pct: 8'd0, known: 1'b0, w16: '0, w63: '0};
        tests[2] = '{block: '1, stall_pct: 8'd30, known: 1'b0, w16: '0, w63: '0};
        // "abc" with padding and a 24-bit length
        tests[3] = '{block: {32'h61626380, 448'h0, 32'h00000018}, stall_pct: 8'd0,
                     known: 1'b1, w16: 32'h61626380, w63: 32'h12b1edeb};
        for (int k = 0; k < BLOCK_WORDS; k++)
            flat[511 - 32*k -: 32] = $urandom;
        tests[4] = '{block: flat, stall_pct: 8'd50, known: 1'b0, w16: '0, w63: '0};
    endtask

    ////////////////////////////////////////////////////////////
    // byte and word streams
    ////////////////////////////////////////////////////////////

    // called on a falling edge, returns on the falling edge after the take
    task automatic send_byte(input byte_t b);
        byte_valid = 1'b1;
        byte_data  = b;
        while (!byte_ready)
            @(negedge clk);
        @(negedge clk);
        bytes_sent++;
    endtask

    task automatic stream_blocks();
        logic [511:0] flat;
        for (int e = 0; e < NUM_BLOCKS; e++)
        begin
            flat = tests[e].block;
            for (int k = 0; k < BLOCK_BYTES; k++)
                send_byte(flat[511 - 8*k -: 8]);
        end
        byte_valid = 1'b0;
    endtask

    task automatic collect_words();
        int blk;
        int t;
        int cycle;
        int first_cycle;
        blk         = 0;
        t           = 0;
        cycle       = 0;
        first_cycle = 0;

        // outputs held until the loader backs up with a second block
        word_ready = 1'b0;
        while (!(word_valid && !byte_ready))
            @(negedge clk);
        for (int i = 0; i < HOLD_CYCLES; i++)
        begin
            @(negedge clk);
            check_equal(byte_ready, 1'b0, "byte_ready while words are held");
        end
        check_equal(bytes_sent, 2 * BLOCK_BYTES, "bytes taken while words are held");

        build_expected(tests[0].block);
        while (blk < NUM_BLOCKS)
        begin
            @(negedge clk);
            cycle++;
            word_ready = (($urandom % 100) >= tests[blk].stall_pct);
            if (word_valid && word_ready)
            begin
                if (t == 0)
                    first_cycle = cycle;
                check_equal(word.data, expected[t], $sformatf("block %0d W%0d", blk, t));
                check_equal(word.index, t, "word index");
                check_equal(word.last, (t == SCHED_ROUNDS - 1), "last flag");
                if (tests[blk].known && t == 16)
                    check_equal(word.data, tests[blk].w16, "published W16");
                if (tests[blk].known && t == SCHED_ROUNDS - 1)
                    check_equal(word.data, tests[blk].w63, "published W63");
                // no stalls means one word per cycle
                if (tests[blk].stall_pct == 0)
                    check_equal(cycle - first_cycle, t, "cycles since word 0");
                if (t == SCHED_ROUNDS - 1)
                begin
                    blk++;
                    t = 0;
                    if (blk < NUM_BLOCKS)
                        build_expected(tests[blk].block);
                end
                else
                    t++;
            end
        end
        @(negedge clk);
        word_ready = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial
    begin
        reset      = 1'b1;
        byte_valid = 1'b0;
        byte_data  = '0;
        word_ready = 1'b0;
        bytes_sent = 0;
        void'($urandom(32'hc49b));
        fill_table();

        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_equal(byte_ready, 1'b1, "byte_ready after reset");
        check_equal(word_valid, 1'b0, "word_valid after reset");

        fork
            stream_blocks();
            collect_words();
        join

        // no word beyond the last block
        for (int i = 0; i < HOLD_CYCLES; i++)
        begin
            @(negedge clk);
            check_equal(word_valid, 1'b0, "word_valid after the last block");
        end
        $display("TEST PASS");
        $finish;
    end

    initial
    begin
        #((NUM_BLOCKS * 200 + 100) * CLK_PERIOD);
        $display("timeout: the schedule words did not all arrive in time");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/sha_sched_pkg.sv
hw/msg_block_loader.sv
hw/msg_schedule_expander.sv
hw/sha_msg_schedule.sv
verif/tb_clock_gen.sv
verif/tb_sha_msg_schedule.sv
